// ==== all.f ====
+incdir+source
source/fir_pkg.sv
source/fir_tap_bank.sv
source/fir_sum.sv
source/fir_filter.sv
source/fir_block_buffer.sv
source/fir_wb_regs.sv
source/fir_top.sv
testbench/fir_assertions.sv
testbench/fir_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FIR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fir_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vfir_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if echo "$output" | grep -qF "All tests passed!"; then
   exit 0
fi
exit 1

// ==== source/fir_block_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_block_buffer (
   input  wire                                  wb_clk_i,
   input  wire                                  wb_rst_i,
   input  fir_pkg::fir_buf_req_t                buf_req_i,
   input  wire                                  start_i,
   input  wire [$clog2(`FIR_BLOCK_LEN)-1:0]     rd_idx_i,
   output logic [`FIR_DW-1:0]                   rd_data_o,
   output fir_pkg::fir_sample_t                 sample_o,
   input  fir_pkg::fir_sample_t                 result_i,
   output logic                                 done_o,
   output logic                                 busy_o
);

   localparam int IW = $clog2(`FIR_BLOCK_LEN);

   logic [`FIR_DW-1:0] in_mem  [`FIR_BLOCK_LEN];
   logic [`FIR_DW-1:0] out_mem [`FIR_BLOCK_LEN];

   logic [IW-1:0] rd_cnt;
   logic [IW-1:0] wr_cnt;
   logic          streaming;
   logic          start_ok;

   // a start while busy is dropped
   assign start_ok  = start_i & ~busy_o;
   assign rd_data_o = out_mem[rd_idx_i];

   always_ff @(posedge wb_clk_i) begin
      if (buf_req_i.strobe) begin
         in_mem[buf_req_i.idx] <= buf_req_i.data;
      end
      if (result_i.strobe && busy_o) begin
         out_mem[wr_cnt] <= result_i.value;
      end
   end

   // read side, sample 0 goes out with the start
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         rd_cnt          <= '0;
         streaming       <= 1'b0;
         sample_o.strobe <= 1'b0;
      end else if (start_ok) begin
         rd_cnt          <= IW'(1);
         streaming       <= 1'b1;
         sample_o.strobe <= 1'b1;
         sample_o.value  <= in_mem[0];
      end else if (streaming) begin
         rd_cnt          <= rd_cnt + 1'b1;
         sample_o.strobe <= 1'b1;
         sample_o.value  <= in_mem[rd_cnt];
         if (rd_cnt == IW'(`FIR_BLOCK_LEN - 1)) begin
            streaming <= 1'b0;
         end
      end else begin
         sample_o.strobe <= 1'b0;
      end
   end

   // write side and status
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         wr_cnt <= '0;
         busy_o <= 1'b0;
         done_o <= 1'b0;
      end else if (start_ok) begin
         wr_cnt <= '0;
         busy_o <= 1'b1;
         done_o <= 1'b0;
      end else if (result_i.strobe && busy_o) begin
         wr_cnt <= wr_cnt + 1'b1;
         if (wr_cnt == IW'(`FIR_BLOCK_LEN - 1)) begin
            busy_o <= 1'b0;
            done_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/fir_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_filter (
   input  wire                     wb_clk_i,
   input  wire                     wb_rst_i,
   input  wire                     clear_i,
   input  fir_pkg::fir_sample_t    sample_i,
   output fir_pkg::fir_sample_t    result_o
);

   localparam int HALF = `FIR_TAPS / 2;

   // previous samples, hist[0] is the newest
   logic [`FIR_TAPS-2:0][`FIR_DW-1:0] hist;
   logic [`FIR_TAPS-1:0][`FIR_DW-1:0] taps;
   logic [HALF-1:0][`FIR_DW-1:0]      even_taps;
   logic [HALF-1:0][`FIR_DW-1:0]      odd_taps;

   fir_pkg::fir_partial_t even_part;
   fir_pkg::fir_partial_t odd_part;

   assign taps = {hist, sample_i.value};

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i || clear_i) begin
         hist <= '0;
      end else if (sample_i.strobe) begin
         hist <= {hist[`FIR_TAPS-3:0], sample_i.value};
      end
   end

   // split history into the two phases
   for (genvar j = 0; j < HALF; j++) begin : g_split
      assign even_taps[j] = taps[2*j];
      assign odd_taps[j]  = taps[2*j+1];
   end

   fir_tap_bank #(.PHASE(0)) u_even (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .taps_i    (even_taps),
      .strobe_i  (sample_i.strobe),
      .partial_o (even_part)
   );

   fir_tap_bank #(.PHASE(1)) u_odd (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .taps_i    (odd_taps),
      .strobe_i  (sample_i.strobe),
      .partial_o (odd_part)
   );

   fir_sum u_sum (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .even_i   (even_part),
      .odd_i    (odd_part),
      .result_o (result_o)
   );

endmodule

`default_nettype wire

// ==== source/fir_macros.svh ====
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// filter geometry
`define FIR_TAPS 8
`define FIR_BLOCK_LEN 32
`define FIR_DW 32

// fixed symmetric coefficients, tap 0 first
`define FIR_COEF_0 32'd1
`define FIR_COEF_1 32'd2
`define FIR_COEF_2 32'd3
`define FIR_COEF_3 32'd4
`define FIR_COEF_4 32'd4
`define FIR_COEF_5 32'd3
`define FIR_COEF_6 32'd2
`define FIR_COEF_7 32'd1

`endif

// ==== source/fir_pkg.sv ====
`default_nettype none

`include "fir_macros.svh"

package fir_pkg;

   // sample into the filter, or result out of it
   typedef struct packed {
      logic                 strobe;
      logic [`FIR_DW-1:0]   value;
   } fir_sample_t;

   // registered output of one tap bank
   typedef struct packed {
      logic                 valid;
      logic [`FIR_DW-1:0]   value;
   } fir_partial_t;

   // input buffer write from the register map
   typedef struct packed {
      logic                                strobe;
      logic [$clog2(`FIR_BLOCK_LEN)-1:0]   idx;
      logic [`FIR_DW-1:0]                  data;
   } fir_buf_req_t;

   typedef struct packed {
      logic start;
      logic irq_en;
   } fir_ctrl_t;

endpackage

`default_nettype wire

// ==== source/fir_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_sum (
   input  wire                     wb_clk_i,
   input  wire                     wb_rst_i,
   input  fir_pkg::fir_partial_t   even_i,
   input  fir_pkg::fir_partial_t   odd_i,
   output fir_pkg::fir_sample_t    result_o
);

   // both banks run in lockstep
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         result_o.strobe <= 1'b0;
      end else begin
         result_o.strobe <= even_i.valid & odd_i.valid;
      end
      result_o.value <= even_i.value + odd_i.value;
   end

endmodule

`default_nettype wire

// ==== source/fir_tap_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_tap_bank #(
   parameter int PHASE = 0
) (
   input  wire                                      wb_clk_i,
   input  wire                                      wb_rst_i,
   input  wire [`FIR_TAPS/2-1:0][`FIR_DW-1:0]       taps_i,
   input  wire                                      strobe_i,
   output fir_pkg::fir_partial_t                    partial_o
);

   localparam logic [`FIR_DW-1:0] COEFS [`FIR_TAPS] = '{
      `FIR_COEF_0, `FIR_COEF_1, `FIR_COEF_2, `FIR_COEF_3,
      `FIR_COEF_4, `FIR_COEF_5, `FIR_COEF_6, `FIR_COEF_7
   };

   logic [`FIR_DW-1:0] acc;

   // products truncated to the data width
   always_comb begin
      acc = '0;
      for (int j = 0; j < `FIR_TAPS / 2; j++) begin
         acc = acc + `FIR_DW'(taps_i[j] * COEFS[2*j + PHASE]);
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         partial_o.valid <= 1'b0;
      end else begin
         partial_o.valid <= strobe_i;
      end
      partial_o.value <= acc;
   end

endmodule

`default_nettype wire

// ==== source/fir_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_top (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   input  wire [31:0]           wb_adr_i,
   input  wire [`FIR_DW-1:0]    wb_dat_i,
   input  wire [3:0]            wb_sel_i,
   input  wire                  wb_we_i,
   input  wire                  wb_stb_i,
   input  wire                  wb_cyc_i,
   output logic [`FIR_DW-1:0]   wb_dat_o,
   output logic                 wb_ack_o,
   output logic                 wb_err_o,
   output logic                 int_o
);

   fir_pkg::fir_buf_req_t buf_req;
   fir_pkg::fir_ctrl_t    ctrl;
   fir_pkg::fir_sample_t  sample;
   fir_pkg::fir_sample_t  result;

   logic [$clog2(`FIR_BLOCK_LEN)-1:0] rd_idx;
   logic [`FIR_DW-1:0]                rd_data;
   logic                              done;
   logic                              busy;
   logic                              filter_clear;

   // only an accepted start wipes the delay line
   assign filter_clear = ctrl.start & ~busy;
   assign int_o        = done & ctrl.irq_en;

   fir_wb_regs u_regs (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .wb_adr_i  (wb_adr_i),
      .wb_dat_i  (wb_dat_i),
      .wb_we_i   (wb_we_i),
      .wb_stb_i  (wb_stb_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .wb_err_o  (wb_err_o),
      .buf_req_o (buf_req),
      .ctrl_o    (ctrl),
      .rd_idx_o  (rd_idx),
      .rd_data_i (rd_data),
      .done_i    (done),
      .busy_i    (busy)
   );

   fir_block_buffer u_buf (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .buf_req_i (buf_req),
      .start_i   (ctrl.start),
      .rd_idx_i  (rd_idx),
      .rd_data_o (rd_data),
      .sample_o  (sample),
      .result_i  (result),
      .done_o    (done),
      .busy_o    (busy)
   );

   fir_filter u_filter (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .clear_i  (filter_clear),
      .sample_i (sample),
      .result_o (result)
   );

endmodule

`default_nettype wire

// ==== source/fir_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_wb_regs (
   input  wire                                  wb_clk_i,
   input  wire                                  wb_rst_i,
   input  wire [31:0]                           wb_adr_i,
   input  wire [`FIR_DW-1:0]                    wb_dat_i,
   input  wire                                  wb_we_i,
   input  wire                                  wb_stb_i,
   input  wire                                  wb_cyc_i,
   output logic [`FIR_DW-1:0]                   wb_dat_o,
   output logic                                 wb_ack_o,
   output logic                                 wb_err_o,
   output fir_pkg::fir_buf_req_t                buf_req_o,
   output fir_pkg::fir_ctrl_t                   ctrl_o,
   output logic [$clog2(`FIR_BLOCK_LEN)-1:0]    rd_idx_o,
   input  wire [`FIR_DW-1:0]                    rd_data_i,
   input  wire                                  done_i,
   input  wire                                  busy_i
);

   localparam int IW = $clog2(`FIR_BLOCK_LEN);

   logic [IW-1:0] in_addr;
   logic [IW-1:0] out_addr;
   logic          bus_wr;

   // single-cycle handshake, no wait states
   assign wb_ack_o = wb_cyc_i & wb_stb_i;
   assign wb_err_o = 1'b0;
   assign bus_wr   = wb_cyc_i & wb_stb_i & wb_we_i;
   assign rd_idx_o = out_addr;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         in_addr          <= '0;
         out_addr         <= '0;
         ctrl_o           <= '0;
         buf_req_o.strobe <= 1'b0;
      end else begin
         // strobes last one cycle
         ctrl_o.start     <= 1'b0;
         buf_req_o.strobe <= 1'b0;
         if (bus_wr) begin
            case (wb_adr_i[5:2])
               4'd0: begin
                  ctrl_o.start  <= wb_dat_i[0];
                  ctrl_o.irq_en <= wb_dat_i[1];
               end
               4'd2: in_addr <= wb_dat_i[IW-1:0];
               4'd3: begin
                  buf_req_o.strobe <= 1'b1;
                  buf_req_o.idx    <= in_addr;
                  buf_req_o.data   <= wb_dat_i;
                  in_addr          <= in_addr + 1'b1;
               end
               4'd4: out_addr <= wb_dat_i[IW-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (wb_adr_i[5:2])
         4'd1:    wb_dat_o = {{(`FIR_DW-2){1'b0}}, busy_i, done_i};
         4'd2:    wb_dat_o = {{(`FIR_DW-IW){1'b0}}, in_addr};
         4'd4:    wb_dat_o = {{(`FIR_DW-IW){1'b0}}, out_addr};
         4'd5:    wb_dat_o = rd_data_i;
         default: wb_dat_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== testbench/fir_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_assertions (
   input wire                  wb_clk_i,
   input wire                  wb_rst_i,
   input wire [31:0]           wb_adr_i,
   input wire [31:0]           wb_dat_i,
   input wire                  wb_we_i,
   input wire                  wb_cyc_i,
   input wire                  wb_stb_i,
   input wire                  wb_ack_i,
   input wire                  wb_err_i,
   input wire                  int_i,
   input wire                  done_i,
   input wire                  busy_i,
   input wire                  start_ok_i
);

   logic irq_en_seen;

   // irq enable as last written to CTRL over the bus
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         irq_en_seen <= 1'b0;
      end else if (wb_cyc_i && wb_stb_i && wb_we_i && wb_adr_i[5:2] == 4'd0) begin
         irq_en_seen <= wb_dat_i[1];
      end
   end

   // ack in the same cycle and never an error
   ack_follows_strobe: assert property (@(posedge wb_clk_i)
      wb_ack_i == (wb_cyc_i && wb_stb_i))
      else $error("wb_ack_o does not match wb_cyc_i and wb_stb_i");

   err_never_high: assert property (@(posedge wb_clk_i) !wb_err_i)
      else $error("wb_err_o went high");

   reset_clears_status: assert property (@(posedge wb_clk_i)
      wb_rst_i |=> !done_i && !busy_i && !int_i)
      else $error("status or interrupt not low after reset");

   irq_follows_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      int_i == (done_i && irq_en_seen))
      else $error("int_o is not done gated by irq enable");

   done_excludes_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(done_i && busy_i))
      else $error("done and busy are high together");

   start_clears_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      start_ok_i |=> !done_i)
      else $error("accepted start did not clear done");

   // a full run is 35 cycles even with a start while busy
   done_after_start: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $past(start_ok_i, 35) |-> $rose(done_i))
      else $error("done did not rise 35 cycles after start");

   done_only_from_start: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(done_i) |-> $past(start_ok_i, 35))
      else $error("done rose at the wrong time");

   busy_fixed_length: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $fell(busy_i) |-> $past(start_ok_i, 35))
      else $error("busy did not last exactly the block run");

endmodule

bind fir_top fir_assertions u_assertions (
   .wb_clk_i   (wb_clk_i),
   .wb_rst_i   (wb_rst_i),
   .wb_adr_i   (wb_adr_i),
   .wb_dat_i   (wb_dat_i),
   .wb_we_i    (wb_we_i),
   .wb_cyc_i   (wb_cyc_i),
   .wb_stb_i   (wb_stb_i),
   .wb_ack_i   (wb_ack_o),
   .wb_err_i   (wb_err_o),
   .int_i      (int_o),
   .done_i     (done),
   .busy_i     (busy),
   .start_ok_i (filter_clear)
);

`default_nettype wire

// ==== testbench/fir_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_tb;

   localparam int BLOCK_LEN = 32;
   // register checks plus three blocks of about 140 cycles, wide margin
   localparam int MAX_CYCLES = 3000;
   localparam int POLL_LIMIT = 60;
   localparam logic [31:0] LFSR_SEED = 32'h8b2972e6;
   localparam logic [31:0] LFSR_MASK = 32'h80200003;
   localparam logic [7:0][31:0] COEF = {32'd1, 32'd2, 32'd3, 32'd4,
                                        32'd4, 32'd3, 32'd2, 32'd1};
   localparam logic [3:0] REG_CTRL     = 4'd0;
   localparam logic [3:0] REG_STATUS   = 4'd1;
   localparam logic [3:0] REG_IN_ADDR  = 4'd2;
   localparam logic [3:0] REG_DATA_IN  = 4'd3;
   localparam logic [3:0] REG_OUT_ADDR = 4'd4;
   localparam logic [3:0] REG_DATA_OUT = 4'd5;

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic        int_o;

   logic [31:0] lfsr_state;
   logic [31:0] samples [BLOCK_LEN];
   int          value_errors;
   int          other_errors;
   int          cycle_count;

   fir_top dut (.*);

   initial begin
      wb_clk_i = 1'b0;
      forever #10 wb_clk_i = ~wb_clk_i;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_MASK;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int b = 0; b < count; b++) begin
         value      = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return value;
   endfunction

   // y[n] = sum of coef[k] * x[n-k], zero history before the block
   function automatic logic [31:0] expected_output(input int n);
      logic [31:0] acc;
      acc = '0;
      for (int k = 0; k < 8; k++) begin
         if (n - k >= 0) begin
            acc = acc + COEF[k] * samples[n - k];
         end
      end
      return acc;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge wb_clk_i);
         #1;
      end
   endtask

   task automatic write_reg(input logic [3:0] word, input logic [31:0] data);
      wb_adr_i = {26'b0, word, 2'b00};
      wb_dat_i = data;
      wb_we_i  = 1'b1;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      @(posedge wb_clk_i);
      #1;
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   task automatic read_reg(input logic [3:0] word, output logic [31:0] data);
      wb_adr_i = {26'b0, word, 2'b00};
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      #8;
      data = wb_dat_o;
      @(posedge wb_clk_i);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   task automatic check_registers();
      logic [31:0] data;
      read_reg(REG_STATUS, data);
      check_value("STATUS", 32'h0, data);
      write_reg(REG_IN_ADDR, 32'd5);
      read_reg(REG_IN_ADDR, data);
      check_value("IN_ADDR", 32'd5, data);
      write_reg(REG_OUT_ADDR, 32'd17);
      read_reg(REG_OUT_ADDR, data);
      check_value("OUT_ADDR", 32'd17, data);
      write_reg(REG_DATA_IN, 32'h123);
      write_reg(REG_DATA_IN, 32'h456);
      read_reg(REG_IN_ADDR, data);
      check_value("IN_ADDR", 32'd7, data);
   endtask

   task automatic load_block();
      logic [31:0] data;
      write_reg(REG_IN_ADDR, 32'd0);
      for (int i = 0; i < BLOCK_LEN; i++) begin
         samples[i] = take_bits(12);
         write_reg(REG_DATA_IN, samples[i]);
      end
      // 32 writes wrap the address back to 0
      read_reg(REG_IN_ADDR, data);
      check_value("IN_ADDR", 32'd0, data);
   endtask

   task automatic wait_done();
      logic [31:0] status;
      int          polls;
      status = '0;
      polls  = 0;
      while (!status[0] && polls < POLL_LIMIT) begin
         read_reg(REG_STATUS, status);
         polls++;
      end
      if (!status[0]) begin
         $display("done flag did not rise within %0d status polls", POLL_LIMIT);
         other_errors++;
      end
   endtask

   task automatic run_block(input logic irq_en, input logic restart);
      logic [31:0] status;
      write_reg(REG_CTRL, {30'b0, irq_en, 1'b1});
      if (restart) begin
         idle(4);
         // block is busy now, this start has to be dropped
         write_reg(REG_CTRL, {30'b0, irq_en, 1'b1});
      end else begin
         idle(1);
      end
      read_reg(REG_STATUS, status);
      check_value("STATUS", 32'h2, status);
      wait_done();
      read_reg(REG_STATUS, status);
      check_value("STATUS", 32'h1, status);
      check_value("int_o", {31'b0, irq_en}, {31'b0, int_o});
   endtask

   task automatic check_results();
      logic [31:0] data;
      for (int i = 0; i < BLOCK_LEN; i++) begin
         write_reg(REG_OUT_ADDR, 32'(i));
         read_reg(REG_DATA_OUT, data);
         check_value($sformatf("DATA_OUT[%0d]", i), expected_output(i), data);
      end
   endtask

   initial begin
      wb_rst_i     = 1'b1;
      wb_adr_i     = '0;
      wb_dat_i     = '0;
      wb_sel_i     = 4'hf;
      wb_we_i      = 1'b0;
      wb_stb_i     = 1'b0;
      wb_cyc_i     = 1'b0;
      lfsr_state   = LFSR_SEED;
      value_errors = 0;
      other_errors = 0;
      repeat (16) @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;

      check_registers();
      load_block();
      run_block(1'b0, 1'b0);
      check_results();
      // fresh samples, history must start from zero again
      load_block();
      run_block(1'b1, 1'b1);
      check_results();
      load_block();
      run_block(1'b0, 1'b0);
      check_results();

      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge wb_clk_i);
         cycle_count++;
      end
      other_errors++;
      $display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire
